/* display_pkg.sv */
package display_pkg;

	// default panel geometry, two segments of eight rows by thirty-two columns
	localparam int def_segments = 2;
	localparam int def_rows = 8;
	localparam int def_columns = 32;
	localparam int def_bitdepth = 8;

	// red, green and blue per pixel
	localparam int colors = 3;

	// one color channel intensity
	typedef logic [def_bitdepth-1:0] channel_t;

	// all channels of one segment pixel, red in the low channel
	typedef channel_t [colors-1:0] pixel_t;

	// index width, at least one bit so single-entry ranges still get a counter
	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	// bits in one buffer word: every channel of every segment
	function automatic int word_w(input int segs, input int depth);
		return segs * colors * depth;
	endfunction

endpackage

/* link_pkg.sv */
package link_pkg;

	// payload bits per uart frame
	localparam int data_bits = 8;

	// start bit, payload and one stop bit on the line
	localparam int frame_bits = data_bits + 2;

	// one serial byte
	typedef logic [data_bits-1:0] byte_t;

	// sent once per buffer swap
	localparam byte_t ack_byte = 8'he0;

endpackage

/* pixel_wr_if.sv */
`timescale 1ns/1ps

interface pixel_wr_if #(
	parameter int segments = 2,
	parameter int rows = 8,
	parameter int columns = 32,
	parameter int bitdepth = 8
);
	logic wen;
	logic [display_pkg::idx_w(rows)-1:0] wrow;
	logic [display_pkg::idx_w(columns)-1:0] wcol;
	logic [display_pkg::word_w(segments, bitdepth)-1:0] wdata;

	// no handshake, the buffer takes every cycle with wen high
	modport loader (output wen, wrow, wcol, wdata);
	modport buffer (input wen, wrow, wcol, wdata);
endinterface

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int clk_div = 868
) (
	input logic clk,
	input logic rst_n,
	input logic rxi,
	output link_pkg::byte_t data,
	output logic valid
);
	localparam int cnt_w = $clog2(clk_div);
	localparam int idx_w = $clog2(link_pkg::data_bits);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(clk_div - 1);
	localparam logic [cnt_w-1:0] half_last = cnt_w'(clk_div / 2 - 1);
	localparam logic [idx_w-1:0] idx_last = idx_w'(link_pkg::data_bits - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	state_t state;
	logic [1:0] sync;
	logic [cnt_w-1:0] cnt;
	logic [idx_w-1:0] idx;
	link_pkg::byte_t shreg;

	// shreg only moves during the next frame's data bits, so it holds through valid
	assign data = shreg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// line idles high
			sync <= '1;
			state <= st_idle;
			cnt <= '0;
			idx <= '0;
			valid <= 1'b0;
		end else begin
			sync <= {sync[0], rxi};
			valid <= 1'b0;
			case (state)
				st_idle: begin
					// falling edge, wait half a bit to land mid start bit
					if (!sync[1]) begin
						cnt <= half_last;
						state <= st_start;
					end
				end
				st_start: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (!sync[1]) begin
						cnt <= bit_last;
						idx <= '0;
						state <= st_data;
					end else begin
						// glitch, not a real start bit
						state <= st_idle;
					end
				end
				st_data: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= bit_last;
						if (idx == idx_last) begin
							state <= st_stop;
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				default: begin
					// mid stop bit, a low line here is a framing error
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						valid <= sync[1];
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == st_data && cnt == '0) begin
			shreg <= {sync[1], shreg[link_pkg::data_bits-1:1]};
		end
	end
endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
	parameter int clk_div = 868
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input link_pkg::byte_t data,
	output logic txo
);
	localparam int cnt_w = $clog2(clk_div);
	localparam int num_w = $clog2(link_pkg::frame_bits);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(clk_div - 1);
	localparam logic [num_w-1:0] num_last = num_w'(link_pkg::frame_bits - 1);

	logic [link_pkg::frame_bits-1:0] shreg;
	logic [cnt_w-1:0] cnt;
	logic [num_w-1:0] num;
	logic busy;

	// bit 0 of the frame register is the line itself
	assign txo = shreg[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shreg <= '1;
			cnt <= '0;
			num <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				// stop, payload, start
				shreg <= {1'b1, data, 1'b0};
				cnt <= bit_last;
				num <= '0;
				busy <= 1'b1;
			end
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			// ones shift in behind the frame so the line returns to idle
			shreg <= {1'b1, shreg[link_pkg::frame_bits-1:1]};
			cnt <= bit_last;
			if (num == num_last) begin
				busy <= 1'b0;
			end else begin
				num <= num + 1'b1;
			end
		end
	end
endmodule

/* data_loader.sv */
`timescale 1ns/1ps

module data_loader #(
	parameter int segments = 2,
	parameter int rows = 8,
	parameter int columns = 32,
	parameter int bitdepth = 8
) (
	input logic clk,
	input logic rst_n,
	input logic ready,
	input logic ivalid,
	input link_pkg::byte_t idata,
	pixel_wr_if.loader wr,
	output logic loaded
);
	localparam int chan_w = display_pkg::idx_w(display_pkg::colors);
	localparam int seg_w = display_pkg::idx_w(segments);
	localparam int col_w = display_pkg::idx_w(columns);
	localparam int row_w = display_pkg::idx_w(rows);
	localparam int data_w = display_pkg::word_w(segments, bitdepth);
	localparam logic [chan_w-1:0] last_chan = chan_w'(display_pkg::colors - 1);
	localparam logic [seg_w-1:0] last_seg = seg_w'(segments - 1);
	localparam logic [col_w-1:0] last_col = col_w'(columns - 1);
	localparam logic [row_w-1:0] last_row = row_w'(rows - 1);

	logic [chan_w-1:0] chan;
	logic [seg_w-1:0] seg;
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic [data_w-1:0] word;
	logic wen;
	logic take;

	// nothing is accepted while the back half still holds a waiting frame
	assign take = ivalid && ready;

	assign wr.wen = wen;
	assign wr.wrow = row;
	assign wr.wcol = col;
	assign wr.wdata = word;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chan <= '0;
			seg <= '0;
			col <= '0;
			row <= '0;
			wen <= 1'b0;
			loaded <= 1'b0;
		end else begin
			wen <= 1'b0;
			loaded <= 1'b0;
			if (take) begin
				if (chan == last_chan) begin
					chan <= '0;
					if (seg == last_seg) begin
						seg <= '0;
						wen <= 1'b1;
					end else begin
						seg <= seg + 1'b1;
					end
				end else begin
					chan <= chan + 1'b1;
				end
			end
			// position moves on only after the write has used it
			if (wen) begin
				if (col == last_col) begin
					col <= '0;
					if (row == last_row) begin
						row <= '0;
						loaded <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// segment s, channel c sits at word slot s*3+c, red lowest
	always_ff @(posedge clk) begin
		if (take) begin
			word[(seg * display_pkg::colors + chan) * bitdepth +: bitdepth] <= bitdepth'(idata);
		end
	end
endmodule

/* frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
	parameter int segments = 2,
	parameter int rows = 8,
	parameter int columns = 32,
	parameter int bitdepth = 8
) (
	input logic clk,
	input logic flip,
	pixel_wr_if.buffer wr,
	input logic [display_pkg::idx_w(rows)-1:0] rrow,
	input logic [display_pkg::idx_w(columns)-1:0] rcol,
	output logic [display_pkg::word_w(segments, bitdepth)-1:0] rdata
);
	localparam int data_w = display_pkg::word_w(segments, bitdepth);

	// two whole frames, flip picks the half being loaded
	logic [data_w-1:0] mem [2][rows][columns];

	// power-up contents are dark so the first frame shown is blank
	initial begin
		for (int h = 0; h < 2; h++) begin
			for (int r = 0; r < rows; r++) begin
				for (int c = 0; c < columns; c++) begin
					mem[h][r][c] = '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr.wen) begin
			mem[flip][wr.wrow][wr.wcol] <= wr.wdata;
		end
	end

	// reads always come from the other half, one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[!flip][rrow][rcol];
	end
endmodule

/* matrix_driver.sv */
`timescale 1ns/1ps

module matrix_driver #(
	parameter int segments = 2,
	parameter int rows = 8,
	parameter int columns = 32,
	parameter int bitdepth = 8
) (
	input logic clk,
	input logic rst_n,
	output logic [display_pkg::idx_w(rows)-1:0] rrow,
	output logic [display_pkg::idx_w(columns)-1:0] rcol,
	input logic [display_pkg::word_w(segments, bitdepth)-1:0] rdata,
	output logic [segments*display_pkg::colors-1:0] rgb,
	output logic oclk,
	output logic lat,
	output logic oe_n,
	output logic frame_complete,
	output logic [display_pkg::idx_w(rows)-1:0] row
);
	localparam int lanes = segments * display_pkg::colors;
	localparam int col_w = display_pkg::idx_w(columns);
	localparam int row_w = display_pkg::idx_w(rows);
	localparam int plane_w = display_pkg::idx_w(bitdepth);
	localparam int dwell_w = col_w + bitdepth + 1;
	localparam logic [col_w-1:0] last_col = col_w'(columns - 1);
	localparam logic [row_w-1:0] last_row = row_w'(rows - 1);
	localparam logic [plane_w-1:0] last_plane = plane_w'(bitdepth - 1);

	typedef enum logic [2:0] {
		st_blank,
		st_fetch,
		st_shift,
		st_latch,
		st_show
	} state_t;

	state_t state;
	logic ph;
	logic [col_w-1:0] col;
	logic [col_w-1:0] next_col;
	logic [row_w-1:0] cur_row;
	logic [plane_w-1:0] plane;
	logic [dwell_w-1:0] dwell;

	assign next_col = (col == last_col) ? '0 : col + 1'b1;

	// fetch one column ahead while the clock-high half of a bit is out
	assign rcol = (state == st_shift && ph) ? next_col : col;
	assign rrow = cur_row;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_blank;
			ph <= 1'b0;
			col <= '0;
			cur_row <= '0;
			plane <= '0;
			dwell <= '0;
			row <= '0;
			rgb <= '0;
			oclk <= 1'b0;
			lat <= 1'b0;
			oe_n <= 1'b1;
			frame_complete <= 1'b0;
		end else begin
			frame_complete <= 1'b0;
			case (state)
				// gives a flip from the top level time to reach the read port
				st_blank: state <= st_fetch;
				st_fetch: state <= st_shift;
				st_shift: begin
					if (!ph) begin
						oclk <= 1'b0;
						for (int k = 0; k < lanes; k++) begin
							rgb[k] <= rdata[k * bitdepth + plane];
						end
						ph <= 1'b1;
					end else begin
						oclk <= 1'b1;
						ph <= 1'b0;
						col <= next_col;
						if (col == last_col) begin
							state <= st_latch;
						end
					end
				end
				st_latch: begin
					oclk <= 1'b0;
					lat <= 1'b1;
					// row pins move here, output is still blanked
					row <= cur_row;
					dwell <= dwell_w'(columns) << plane;
					state <= st_show;
				end
				default: begin
					lat <= 1'b0;
					if (dwell != '0) begin
						oe_n <= 1'b0;
						dwell <= dwell - 1'b1;
					end else begin
						oe_n <= 1'b1;
						state <= st_blank;
						if (plane == last_plane) begin
							plane <= '0;
							if (cur_row == last_row) begin
								cur_row <= '0;
								frame_complete <= 1'b1;
							end else begin
								cur_row <= cur_row + 1'b1;
							end
						end else begin
							plane <= plane + 1'b1;
						end
					end
				end
			endcase
		end
	end
endmodule

/* led_matrix_top.sv */
`timescale 1ns/1ps

module led_matrix_top #(
	parameter int segments = display_pkg::def_segments,
	parameter int rows = display_pkg::def_rows,
	parameter int columns = display_pkg::def_columns,
	parameter int bitdepth = display_pkg::def_bitdepth,
	parameter int clk_div = 868
) (
	input logic clk,
	input logic rst_n,
	input logic uart_rxi,
	output logic uart_txo,
	output logic oe,
	output logic lat,
	output logic oclk,
	output logic [display_pkg::idx_w(rows)-1:0] a,
	output logic [segments*display_pkg::colors-1:0] rgb
);
	logic [display_pkg::idx_w(rows)-1:0] rrow;
	logic [display_pkg::idx_w(columns)-1:0] rcol;
	logic [display_pkg::word_w(segments, bitdepth)-1:0] rdata;
	link_pkg::byte_t rx_data;
	logic rx_valid;
	logic loaded;
	logic frame_complete;
	logic ready;
	logic flip;
	logic swapped;

	pixel_wr_if #(
		.segments(segments), .rows(rows), .columns(columns), .bitdepth(bitdepth)
	) wr ();

	// ready low means a loaded frame waits in the back half for the next frame end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ready <= 1'b1;
			flip <= 1'b0;
			swapped <= 1'b0;
		end else begin
			swapped <= 1'b0;
			if (frame_complete && !ready) begin
				flip <= ~flip;
				ready <= 1'b1;
				swapped <= 1'b1;
			end else if (loaded && ready) begin
				ready <= 1'b0;
			end
		end
	end

	uart_rx #(.clk_div(clk_div)) u_uart_rx (
		.clk(clk), .rst_n(rst_n), .rxi(uart_rxi), .data(rx_data), .valid(rx_valid)
	);

	data_loader #(
		.segments(segments), .rows(rows), .columns(columns), .bitdepth(bitdepth)
	) u_loader (
		.clk(clk), .rst_n(rst_n), .ready(ready), .ivalid(rx_valid), .idata(rx_data),
		.wr(wr.loader), .loaded(loaded)
	);

	frame_buffer #(
		.segments(segments), .rows(rows), .columns(columns), .bitdepth(bitdepth)
	) u_buffer (
		.clk(clk), .flip(flip), .wr(wr.buffer), .rrow(rrow), .rcol(rcol), .rdata(rdata)
	);

	// panel output enable is active low
	matrix_driver #(
		.segments(segments), .rows(rows), .columns(columns), .bitdepth(bitdepth)
	) u_driver (
		.clk(clk), .rst_n(rst_n), .rrow(rrow), .rcol(rcol), .rdata(rdata), .rgb(rgb),
		.oclk(oclk), .lat(lat), .oe_n(oe), .frame_complete(frame_complete), .row(a)
	);

	uart_tx #(.clk_div(clk_div)) u_uart_tx (
		.clk(clk), .rst_n(rst_n), .start(swapped), .data(link_pkg::ack_byte), .txo(uart_txo)
	);
endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 50
) (
	output logic clk
);
	// 100 ns period, starts low
	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end
endmodule

/* tb_led_matrix.sv */
`timescale 1ns/1ps

module tb_led_matrix;
	localparam int rows = 4;
	localparam int columns = 8;
	localparam int segments = 2;
	localparam int bitdepth = 4;
	localparam int clk_div = 8;
	localparam int colors = display_pkg::colors;
	localparam int lanes = segments * colors;
	localparam int row_w = display_pkg::idx_w(rows);
	localparam int frame_bytes = rows * columns * segments * colors;
	localparam int scan_len = rows * (bitdepth * (2 * columns + 4) + columns * (2 ** bitdepth - 1));
	localparam int drop_len = 4;
	localparam int entries = 6;
	localparam int limit = (entries * frame_bytes * 10 * clk_div + 2 * scan_len) * 5 / 4;
	// acknowledge value the panel controller sends after every swap
	localparam link_pkg::byte_t ack_value = 8'he0;

	typedef enum {fill_const, fill_grad, fill_rand} fill_t;
	typedef struct {
		fill_t kind;
		link_pkg::byte_t base;
		bit ack;
	} entry_t;
	typedef link_pkg::byte_t image_t [rows][columns][segments][colors];

	logic clk;
	logic rst_n = 1'b0;
	logic uart_rxi = 1'b1;
	logic uart_txo;
	logic oe;
	logic lat;
	logic oclk;
	logic [row_w-1:0] a;
	logic [lanes-1:0] rgb;

	entry_t frames [entries];
	image_t front_img;
	image_t back_img;
	image_t load_img;
	integer seed;
	int errors = 0;
	int cyc = 0;
	int acks = 0;
	int swaps = 0;
	int ack_due = 0;
	int frame_ends = 0;
	bit pending = 1'b0;

	// monitor state
	logic prev_oclk;
	logic prev_lat;
	logic prev_oe;
	logic [row_w-1:0] prev_a;
	int bit_cnt;
	int lat_cnt;
	int on_cnt;
	int last_on;
	int cur_row;
	int cur_plane;
	logic [lanes-1:0] shifted [columns];

	tb_clock_gen u_clk (.clk(clk));

	led_matrix_top #(
		.segments(segments), .rows(rows), .columns(columns), .bitdepth(bitdepth),
		.clk_div(clk_div)
	) u_dut (
		.clk(clk), .rst_n(rst_n), .uart_rxi(uart_rxi), .uart_txo(uart_txo), .oe(oe),
		.lat(lat), .oclk(oclk), .a(a), .rgb(rgb)
	);

	task automatic check_pixel_bits(input logic [lanes-1:0] got, input logic [lanes-1:0] exp,
		input string msg);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic check_ack(input link_pkg::byte_t got, input link_pkg::byte_t exp,
		input string msg);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_row(input logic [row_w-1:0] got, input logic [row_w-1:0] exp,
		input string msg);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string msg);
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	function automatic link_pkg::byte_t fill_value(input entry_t e, input int r, input int c,
		input int s, input int ch);
		case (e.kind)
			fill_const: return e.base;
			fill_grad: return link_pkg::byte_t'(e.base + r * 7 + c * 3 + s * 11 + ch * 5);
			default: return link_pkg::byte_t'($random(seed));
		endcase
	endfunction

	// lane s*3+c carries bit p of channel c of segment s
	function automatic logic [lanes-1:0] expected_bits(input int r, input int c, input int p);
		logic [lanes-1:0] v;
		for (int s = 0; s < segments; s++) begin
			for (int ch = 0; ch < colors; ch++) begin
				v[s * colors + ch] = front_img[r][c][s][ch][p];
			end
		end
		return v;
	endfunction

	// start bit, eight data bits lsb first, stop bit
	task automatic send_byte(input link_pkg::byte_t b);
		uart_rxi = 1'b0;
		repeat (clk_div) @(negedge clk);
		for (int i = 0; i < link_pkg::data_bits; i++) begin
			uart_rxi = b[i];
			repeat (clk_div) @(negedge clk);
		end
		uart_rxi = 1'b1;
		repeat (clk_div) @(negedge clk);
	endtask

	task automatic send_frame(input entry_t e);
		int n;
		int fe;
		n = 0;
		// image is built first so random values follow byte order
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < columns; c++)
				for (int s = 0; s < segments; s++)
					for (int ch = 0; ch < colors; ch++)
						load_img[r][c][s][ch] = fill_value(e, r, c, s, ch);
		if (e.ack) begin
			back_img = load_img;
		end
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < columns; c++)
				for (int s = 0; s < segments; s++)
					for (int ch = 0; ch < colors; ch++) begin
						n++;
						// last byte waits for a frame end so loaded lands far from the next one
						if (e.ack && n == frame_bytes) begin
							fe = frame_ends;
							while (frame_ends == fe) @(negedge clk);
						end
						if (e.ack || n <= drop_len) begin
							send_byte(load_img[r][c][s][ch]);
						end
					end
		if (e.ack) begin
			pending = 1'b1;
		end
	endtask

	// panel monitor and reference model sample on the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_oclk = 1'b0;
			prev_lat = 1'b0;
			prev_oe = 1'b1;
			prev_a = '0;
			bit_cnt = 0;
			lat_cnt = 0;
			on_cnt = 0;
			last_on = 0;
			cur_row = 0;
			cur_plane = 0;
		end else begin
			if (oclk && !prev_oclk) begin
				if (!oe) begin
					errors++;
					$display("output enabled while shifting at %0t", $time);
				end
				if (bit_cnt < columns) begin
					shifted[bit_cnt] = rgb;
				end
				bit_cnt++;
			end
			if (a != prev_a && !oe) begin
				errors++;
				$display("row address changed while output enabled at %0t", $time);
			end
			if (lat && !prev_lat) begin
				check_count(bit_cnt, columns, "shift clocks before latch");
				check_row(a, row_w'(cur_row), "row address at latch");
				for (int k = 0; k < columns; k++) begin
					check_pixel_bits(shifted[k], expected_bits(cur_row, k, cur_plane),
						$sformatf("row %0d plane %0d column %0d", cur_row, cur_plane, k));
				end
				bit_cnt = 0;
				lat_cnt++;
			end
			if (!oe) begin
				on_cnt++;
			end
			if (!oe && prev_oe) begin
				check_count(lat_cnt, 1, "latch pulses before output");
				lat_cnt = 0;
			end
			if (oe && !prev_oe) begin
				if (cur_plane > 0) begin
					check_count(on_cnt, 2 * last_on, "on time against previous plane");
				end
				last_on = on_cnt;
				on_cnt = 0;
				if (cur_plane == bitdepth - 1) begin
					cur_plane = 0;
					if (cur_row == rows - 1) begin
						cur_row = 0;
						// a loaded frame waiting at frame end becomes the front
						if (pending) begin
							front_img = back_img;
							pending = 1'b0;
							swaps++;
							ack_due++;
						end
						frame_ends++;
					end else begin
						cur_row++;
					end
				end else begin
					cur_plane++;
				end
			end
			prev_oclk = oclk;
			prev_lat = lat;
			prev_oe = oe;
			prev_a = a;
		end
	end

	// uart decoder for acknowledge bytes
	initial begin
		link_pkg::byte_t got;
		forever begin
			@(negedge clk);
			if (rst_n && !uart_txo) begin
				if (ack_due == 0) begin
					errors++;
					$display("uart_txo went low with no buffer swap at %0t", $time);
				end
				repeat (clk_div / 2) @(negedge clk);
				for (int i = 0; i < link_pkg::data_bits; i++) begin
					repeat (clk_div) @(negedge clk);
					got[i] = uart_txo;
				end
				repeat (clk_div) @(negedge clk);
				if (!uart_txo) begin
					errors++;
					$display("missing stop bit on uart_txo at %0t", $time);
				end
				check_ack(got, ack_value, "acknowledge byte");
				acks++;
				if (ack_due > 0) begin
					ack_due--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= limit) begin
			$display("run stopped at the cycle limit of %0d, errors so far %0d", limit, errors);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		int expected_acks;
		int fe;
		seed = 32'hc93405b2;
		expected_acks = 0;
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < columns; c++)
				for (int s = 0; s < segments; s++)
					for (int ch = 0; ch < colors; ch++)
						front_img[r][c][s][ch] = '0;
		frames[0] = '{fill_grad, 8'h00, 1'b1};
		frames[1] = '{fill_const, 8'h0a, 1'b1};
		frames[2] = '{fill_rand, 8'h00, 1'b1};
		// sent while frame 2 still waits and must vanish
		frames[3] = '{fill_const, 8'hff, 1'b0};
		frames[4] = '{fill_const, 8'h05, 1'b1};
		frames[5] = '{fill_grad, 8'h09, 1'b1};
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < entries; i++) begin
			if (frames[i].ack) begin
				while (pending) @(negedge clk);
				expected_acks++;
			end
			send_frame(frames[i]);
		end
		while (pending) @(negedge clk);
		fe = frame_ends;
		while (frame_ends < fe + 2) @(negedge clk);
		repeat (12 * clk_div) @(negedge clk);
		check_count(acks, expected_acks, "acknowledge bytes");
		$display("errors %0d, frames scanned %0d, swaps %0d, acknowledge bytes %0d",
			errors, frame_ends, swaps, acks);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end
endmodule

/* project.f */
display_pkg.sv
link_pkg.sv
pixel_wr_if.sv
uart_rx.sv
uart_tx.sv
data_loader.sv
frame_buffer.sv
matrix_driver.sv
led_matrix_top.sv
tb_clock_gen.sv
tb_led_matrix.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP = tb_led_matrix
FILELIST = project.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "All checks passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
